// File: common/gru_pkg.sv
`default_nettype none

package gru_pkg;

	////////////////////////////////////////////////////
	// cell sizes and fixed-point format
	////////////////////////////////////////////////////

	localparam int N_INPUTS  = 2;
	localparam int N_NEURONS = 2;
	localparam int FIX_W     = 16;
	localparam int ACC_W     = 32;
	localparam int FRAC_BITS = 8;
	localparam int FIX_ONE   = 1 << FRAC_BITS;
	localparam int FIX_MAX   = 32767;
	localparam int FIX_MIN   = -32768;

	// one row is bias, input weights, recurrent weights
	localparam int ROW_WORDS  = 1 + N_INPUTS + N_NEURONS;
	localparam int GATE_WORDS = N_NEURONS * ROW_WORDS;
	localparam int ROM_WORDS  = 3 * GATE_WORDS;
	localparam int ROM_AW     = 5;

	typedef logic signed [FIX_W-1:0]     fix_t;
	typedef logic signed [ACC_W-1:0]     acc_t;
	typedef logic [N_INPUTS*FIX_W-1:0]   vec_in_t;
	typedef logic [N_NEURONS*FIX_W-1:0]  vec_state_t;
	typedef logic [ROM_AW-1:0]           rom_addr_t;
	typedef logic [2:0]                  term_t;
	typedef logic [0:0]                  neuron_t;

	typedef enum logic [1:0] {
		IDLE,
		GATES,
		CAND
	} seq_state_t;

	// Q16.16 back to Q8.8 with saturation
	function automatic fix_t rescale_sat(input acc_t acc);
		acc_t s;
		s = acc >>> FRAC_BITS;
		if (s > FIX_MAX)
			return fix_t'(FIX_MAX);
		if (s < FIX_MIN)
			return fix_t'(FIX_MIN);
		return fix_t'(s);
	endfunction

endpackage

`default_nettype wire

// File: hw/gru/gru_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module gru_sequencer (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	output logic               busy,
	output gru_pkg::rom_addr_t rom_addr,
	output gru_pkg::term_t     term,
	output gru_pkg::neuron_t   neuron,
	output logic               cand_pass,
	output logic               term_valid,
	output logic               row_last,
	output logic               pass_last,
	input  logic               done
);

	gru_pkg::seq_state_t state;
	gru_pkg::term_t      term_cnt;
	gru_pkg::neuron_t    neuron_cnt;
	logic                issued;
	logic                row_end;
	logic                neuron_end;

	assign row_end    = (term_cnt == gru_pkg::term_t'(gru_pkg::ROW_WORDS - 1));
	assign neuron_end = (neuron_cnt == gru_pkg::neuron_t'(gru_pkg::N_NEURONS - 1));

	////////////////////////////////////////////////////
	// pass / neuron / term walk
	////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= gru_pkg::IDLE;
			term_cnt   <= '0;
			neuron_cnt <= '0;
			issued     <= 1'b0;
		end else begin
			case (state)
				gru_pkg::IDLE: begin
					if (start) begin
						state      <= gru_pkg::GATES;
						term_cnt   <= '0;
						neuron_cnt <= '0;
						issued     <= 1'b0;
					end
				end
				gru_pkg::GATES: begin
					if (row_end) begin
						term_cnt   <= '0;
						neuron_cnt <= neuron_end ? '0 : neuron_cnt + 1'b1;
						if (neuron_end)
							state <= gru_pkg::CAND;
					end else begin
						term_cnt <= term_cnt + 1'b1;
					end
				end
				gru_pkg::CAND: begin
					// hold here until the last state word is written
					if (done) begin
						state <= gru_pkg::IDLE;
					end else if (!issued) begin
						if (row_end) begin
							term_cnt   <= '0;
							neuron_cnt <= neuron_end ? '0 : neuron_cnt + 1'b1;
							issued     <= neuron_end;
						end else begin
							term_cnt <= term_cnt + 1'b1;
						end
					end
				end
				default: state <= gru_pkg::IDLE;
			endcase
		end
	end

	assign busy       = (state != gru_pkg::IDLE);
	assign cand_pass  = (state == gru_pkg::CAND);
	assign term_valid = (state == gru_pkg::GATES) || (cand_pass && !issued);
	assign term       = term_cnt;
	assign neuron     = neuron_cnt;
	assign row_last   = row_end;
	assign pass_last  = term_valid && cand_pass && row_end && neuron_end;

	// gate pass reads the z block, candidate pass the h block
	assign rom_addr = gru_pkg::rom_addr_t'((cand_pass ? 2 * gru_pkg::GATE_WORDS : 0)
		+ int'(neuron_cnt) * gru_pkg::ROW_WORDS + int'(term_cnt));

endmodule

`default_nettype wire

// File: hw/gru/gru_weight_rom.sv
`timescale 1ns/1ns
`default_nettype none

module gru_weight_rom (
	input  logic               clk,
	input  gru_pkg::rom_addr_t rom_addr,
	output gru_pkg::fix_t      weight_a,
	output gru_pkg::fix_t      weight_b
);

	gru_pkg::fix_t mem [gru_pkg::ROM_WORDS];
	logic [gru_pkg::ROM_AW:0] addr_b;

	initial begin
		$readmemh("gru_weights.mem", mem);
	end

	// second word one gate block further on
	assign addr_b = {1'b0, rom_addr} + (gru_pkg::ROM_AW + 1)'(gru_pkg::GATE_WORDS);

	always_ff @(posedge clk) begin
		weight_a <= mem[rom_addr];
		// past the h block there is nothing to pair with
		if (addr_b < (gru_pkg::ROM_AW + 1)'(gru_pkg::ROM_WORDS))
			weight_b <= mem[addr_b[gru_pkg::ROM_AW-1:0]];
		else
			weight_b <= '0;
	end

endmodule

`default_nettype wire

// File: hw/gru/gru_mac.sv
`timescale 1ns/1ns
`default_nettype none

module gru_mac (
	input  logic                clk,
	input  logic                reset,
	input  gru_pkg::term_t      term,
	input  gru_pkg::neuron_t    neuron,
	input  logic                cand_pass,
	input  logic                term_valid,
	input  logic                row_last,
	input  logic                pass_last,
	input  gru_pkg::fix_t       weight_a,
	input  gru_pkg::fix_t       weight_b,
	input  gru_pkg::vec_in_t    x_in,
	input  gru_pkg::vec_state_t h_prev,
	input  gru_pkg::vec_state_t r_vec,
	output logic                act_valid,
	output gru_pkg::neuron_t    act_neuron,
	output logic                act_cand,
	output logic                act_final,
	output gru_pkg::fix_t       act_a,
	output gru_pkg::fix_t       act_b
);

	// hard sigmoid, or hard tanh in the candidate pass
	function automatic gru_pkg::fix_t activate(input gru_pkg::fix_t s, input logic tanh_mode);
		gru_pkg::fix_t t;
		gru_pkg::fix_t lo;
		if (tanh_mode) begin
			t  = s;
			lo = gru_pkg::fix_t'(-gru_pkg::FIX_ONE);
		end else begin
			t  = (s >>> 2) + gru_pkg::fix_t'(gru_pkg::FIX_ONE / 2);
			lo = '0;
		end
		if (t > gru_pkg::fix_t'(gru_pkg::FIX_ONE))
			return gru_pkg::fix_t'(gru_pkg::FIX_ONE);
		if (t < lo)
			return lo;
		return t;
	endfunction

	logic             s1_valid, s1_row_last, s1_pass_last, s1_cand;
	gru_pkg::term_t   s1_term;
	gru_pkg::neuron_t s1_neuron;
	logic             s2_valid, s2_row_last, s2_pass_last, s2_cand, s2_first;
	gru_pkg::neuron_t s2_neuron;
	gru_pkg::fix_t    operand;
	gru_pkg::acc_t    prod_a, prod_b;
	gru_pkg::acc_t    acc_a, acc_b;

	////////////////////////////////////////////////////
	// operand select, lined up with rom data
	////////////////////////////////////////////////////

	always_comb begin
		int            x_idx;
		int            h_idx;
		gru_pkg::fix_t h_j;
		gru_pkg::fix_t r_j;
		gru_pkg::acc_t rh;
		x_idx = (int'(s1_term) + gru_pkg::N_INPUTS - 1) % gru_pkg::N_INPUTS;
		h_idx = (int'(s1_term) - 1 - gru_pkg::N_INPUTS
			+ gru_pkg::N_NEURONS * gru_pkg::ROW_WORDS) % gru_pkg::N_NEURONS;
		h_j   = h_prev[h_idx*gru_pkg::FIX_W +: gru_pkg::FIX_W];
		r_j   = r_vec[h_idx*gru_pkg::FIX_W +: gru_pkg::FIX_W];
		rh    = gru_pkg::acc_t'(r_j) * gru_pkg::acc_t'(h_j);
		// bias times one lands in Q16.16
		if (s1_term == '0)
			operand = gru_pkg::fix_t'(gru_pkg::FIX_ONE);
		else if (int'(s1_term) <= gru_pkg::N_INPUTS)
			operand = x_in[x_idx*gru_pkg::FIX_W +: gru_pkg::FIX_W];
		else if (s1_cand)
			operand = gru_pkg::fix_t'(rh >>> gru_pkg::FRAC_BITS);
		else
			operand = h_j;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid     <= 1'b0;
			s1_row_last  <= 1'b0;
			s1_pass_last <= 1'b0;
			s2_valid     <= 1'b0;
			s2_row_last  <= 1'b0;
			s2_pass_last <= 1'b0;
			act_valid    <= 1'b0;
			act_final    <= 1'b0;
		end else begin
			s1_valid     <= term_valid;
			s1_row_last  <= term_valid && row_last;
			s1_pass_last <= term_valid && pass_last;
			s2_valid     <= s1_valid;
			s2_row_last  <= s1_row_last;
			s2_pass_last <= s1_pass_last;
			act_valid    <= s2_valid && s2_row_last;
			act_final    <= s2_valid && s2_pass_last;
		end
	end

	always_ff @(posedge clk) begin
		s1_term    <= term;
		s1_neuron  <= neuron;
		s1_cand    <= cand_pass;
		s2_first   <= (s1_term == '0);
		s2_neuron  <= s1_neuron;
		s2_cand    <= s1_cand;
		prod_a     <= gru_pkg::acc_t'(weight_a) * gru_pkg::acc_t'(operand);
		prod_b     <= gru_pkg::acc_t'(weight_b) * gru_pkg::acc_t'(operand);
		act_neuron <= s2_neuron;
		act_cand   <= s2_cand;
		// bias term restarts both sums
		if (s2_valid) begin
			acc_a <= s2_first ? prod_a : acc_a + prod_a;
			acc_b <= s2_first ? prod_b : acc_b + prod_b;
		end
	end

	assign act_a = activate(gru_pkg::rescale_sat(acc_a), act_cand);
	assign act_b = activate(gru_pkg::rescale_sat(acc_b), act_cand);

endmodule

`default_nettype wire

// File: hw/gru/gru_state_update.sv
`timescale 1ns/1ns
`default_nettype none

module gru_state_update (
	input  logic                clk,
	input  logic                reset,
	input  logic                act_valid,
	input  gru_pkg::neuron_t    act_neuron,
	input  logic                act_cand,
	input  logic                act_final,
	input  gru_pkg::fix_t       act_a,
	input  gru_pkg::fix_t       act_b,
	input  gru_pkg::vec_state_t h_prev,
	output gru_pkg::vec_state_t r_vec,
	output gru_pkg::vec_state_t h_out,
	output logic                valid,
	output logic                done
);

	gru_pkg::vec_state_t z_vec;
	gru_pkg::vec_state_t h_work;
	gru_pkg::vec_state_t h_merged;
	gru_pkg::fix_t       z_n;
	gru_pkg::fix_t       h_n;
	gru_pkg::acc_t       blend;

	assign z_n = z_vec[act_neuron*gru_pkg::FIX_W +: gru_pkg::FIX_W];
	assign h_n = h_prev[act_neuron*gru_pkg::FIX_W +: gru_pkg::FIX_W];

	// z*h_prev + (1-z)*cand, still Q16.16
	assign blend = gru_pkg::acc_t'(z_n) * gru_pkg::acc_t'(h_n)
		+ (gru_pkg::acc_t'(gru_pkg::FIX_ONE) - gru_pkg::acc_t'(z_n)) * gru_pkg::acc_t'(act_a);

	always_comb begin
		h_merged = h_work;
		h_merged[act_neuron*gru_pkg::FIX_W +: gru_pkg::FIX_W] = gru_pkg::rescale_sat(blend);
	end

	always_ff @(posedge clk) begin
		// gate pass delivers z and r per neuron
		if (act_valid && !act_cand) begin
			z_vec[act_neuron*gru_pkg::FIX_W +: gru_pkg::FIX_W] <= act_a;
			r_vec[act_neuron*gru_pkg::FIX_W +: gru_pkg::FIX_W] <= act_b;
		end
		if (act_valid && act_cand)
			h_work <= h_merged;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			h_out <= '0;
			valid <= 1'b0;
		end else begin
			valid <= act_valid && act_cand && act_final;
			if (act_valid && act_cand && act_final)
				h_out <= h_merged;
		end
	end

	assign done = valid;

endmodule

`default_nettype wire

// File: hw/gru/gru_top.sv
`timescale 1ns/1ns
`default_nettype none

module gru_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,
	input  gru_pkg::vec_in_t    x_in,
	input  gru_pkg::vec_state_t h_prev,
	output gru_pkg::vec_state_t h_out,
	output logic                busy,
	output logic                valid
);

	gru_pkg::rom_addr_t  rom_addr;
	gru_pkg::term_t      term;
	gru_pkg::neuron_t    neuron;
	logic                cand_pass;
	logic                term_valid;
	logic                row_last;
	logic                pass_last;
	logic                done;
	gru_pkg::fix_t       weight_a;
	gru_pkg::fix_t       weight_b;
	logic                act_valid;
	gru_pkg::neuron_t    act_neuron;
	logic                act_cand;
	logic                act_final;
	gru_pkg::fix_t       act_a;
	gru_pkg::fix_t       act_b;
	gru_pkg::vec_state_t r_vec;

	gru_sequencer u_seq (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.busy       (busy),
		.rom_addr   (rom_addr),
		.term       (term),
		.neuron     (neuron),
		.cand_pass  (cand_pass),
		.term_valid (term_valid),
		.row_last   (row_last),
		.pass_last  (pass_last),
		.done       (done)
	);

	gru_weight_rom u_rom (
		.clk      (clk),
		.rom_addr (rom_addr),
		.weight_a (weight_a),
		.weight_b (weight_b)
	);

	gru_mac u_mac (
		.clk        (clk),
		.reset      (reset),
		.term       (term),
		.neuron     (neuron),
		.cand_pass  (cand_pass),
		.term_valid (term_valid),
		.row_last   (row_last),
		.pass_last  (pass_last),
		.weight_a   (weight_a),
		.weight_b   (weight_b),
		.x_in       (x_in),
		.h_prev     (h_prev),
		.r_vec      (r_vec),
		.act_valid  (act_valid),
		.act_neuron (act_neuron),
		.act_cand   (act_cand),
		.act_final  (act_final),
		.act_a      (act_a),
		.act_b      (act_b)
	);

	gru_state_update u_upd (
		.clk        (clk),
		.reset      (reset),
		.act_valid  (act_valid),
		.act_neuron (act_neuron),
		.act_cand   (act_cand),
		.act_final  (act_final),
		.act_a      (act_a),
		.act_b      (act_b),
		.h_prev     (h_prev),
		.r_vec      (r_vec),
		.h_out      (h_out),
		.valid      (valid),
		.done       (done)
	);

endmodule

`default_nettype wire

// File: sim/gru_chk.sv
`timescale 1ns/1ns
`default_nettype none

module gru_chk (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic valid
);

	valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
		valid |=> !valid)
		else $error("valid stayed high for more than one cycle");

	// busy drops right after the result
	busy_falls: assert property (@(posedge clk) disable iff (reset)
		valid |=> !busy)
		else $error("busy still high after valid");

	valid_in_busy: assert property (@(posedge clk) disable iff (reset)
		valid |-> busy)
		else $error("valid without busy");

	start_taken: assert property (@(posedge clk) disable iff (reset)
		start && !busy |=> busy)
		else $error("start in idle did not raise busy");

endmodule

bind gru_top gru_chk u_chk (
	.clk   (clk),
	.reset (reset),
	.start (start),
	.busy  (busy),
	.valid (valid)
);

`default_nettype wire

// File: sim/gru_ref.svh
`ifndef GRU_REF_SVH
`define GRU_REF_SVH

// weights, same layout as the rom
gru_pkg::fix_t ref_weights [gru_pkg::ROM_WORDS];

function automatic gru_pkg::fix_t ref_elem(input logic [31:0] vec, input int i);
	return vec[i*gru_pkg::FIX_W +: gru_pkg::FIX_W];
endfunction

function automatic gru_pkg::acc_t ref_mul(input gru_pkg::fix_t a, input gru_pkg::fix_t b);
	return gru_pkg::acc_t'(a) * gru_pkg::acc_t'(b);
endfunction

// Q16.16 sum down to Q8.8, saturating
function automatic gru_pkg::fix_t ref_sat(input gru_pkg::acc_t sum);
	gru_pkg::acc_t q;
	q = sum >>> gru_pkg::FRAC_BITS;
	if (q > 32'sd32767)
		return 16'sh7fff;
	if (q < -32'sd32768)
		return 16'sh8000;
	return q[15:0];
endfunction

function automatic gru_pkg::fix_t ref_sigmoid(input gru_pkg::fix_t s);
	int t;
	t = (int'(s) >>> 2) + 128;
	if (t < 0)
		return 16'sh0000;
	if (t > 256)
		return 16'sh0100;
	return gru_pkg::fix_t'(t);
endfunction

function automatic gru_pkg::fix_t ref_tanh(input gru_pkg::fix_t s);
	if (s > 256)
		return 16'sh0100;
	if (s < -256)
		return -16'sh0100;
	return s;
endfunction

// bias + inputs + recurrent operand for one neuron row
function automatic gru_pkg::acc_t ref_row(input int base, input int n,
	input gru_pkg::vec_in_t x, input gru_pkg::vec_state_t v);
	gru_pkg::acc_t sum;
	int row;
	int i;
	row = base + n * gru_pkg::ROW_WORDS;
	sum = gru_pkg::acc_t'(ref_weights[row]) <<< gru_pkg::FRAC_BITS;
	for (i = 0; i < gru_pkg::N_INPUTS; i++)
		sum += ref_mul(ref_weights[row + 1 + i], ref_elem(x, i));
	for (i = 0; i < gru_pkg::N_NEURONS; i++)
		sum += ref_mul(ref_weights[row + 1 + gru_pkg::N_INPUTS + i], ref_elem(v, i));
	return sum;
endfunction

function automatic gru_pkg::vec_state_t ref_step(input gru_pkg::vec_in_t x,
	input gru_pkg::vec_state_t h);
	gru_pkg::fix_t       z [gru_pkg::N_NEURONS];
	gru_pkg::fix_t       r [gru_pkg::N_NEURONS];
	gru_pkg::vec_state_t rh;
	gru_pkg::vec_state_t h_new;
	gru_pkg::fix_t       cand;
	gru_pkg::acc_t       mix;
	int                  n;
	for (n = 0; n < gru_pkg::N_NEURONS; n++) begin
		z[n] = ref_sigmoid(ref_sat(ref_row(0, n, x, h)));
		r[n] = ref_sigmoid(ref_sat(ref_row(gru_pkg::GATE_WORDS, n, x, h)));
	end
	// r gates the recurrent input of the candidate
	for (n = 0; n < gru_pkg::N_NEURONS; n++) begin
		mix = ref_mul(r[n], ref_elem(h, n));
		rh[n*gru_pkg::FIX_W +: gru_pkg::FIX_W] = mix[23:8];
	end
	for (n = 0; n < gru_pkg::N_NEURONS; n++) begin
		cand = ref_tanh(ref_sat(ref_row(2 * gru_pkg::GATE_WORDS, n, x, rh)));
		mix  = ref_mul(z[n], ref_elem(h, n))
			+ ref_mul(gru_pkg::fix_t'(gru_pkg::FIX_ONE - int'(z[n])), cand);
		h_new[n*gru_pkg::FIX_W +: gru_pkg::FIX_W] = ref_sat(mix);
	end
	return h_new;
endfunction

`endif

// File: sim/tb_gru.sv
`timescale 1ns/1ns
`default_nettype none

module tb_gru;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int RANDOM_RUNS    = 20;

	logic                clk;
	logic                reset;
	logic                start;
	gru_pkg::vec_in_t    x_in;
	gru_pkg::vec_state_t h_prev;
	gru_pkg::vec_state_t h_out;
	logic                busy;
	logic                valid;
	logic [31:0]         lfsr;
	int                  err_count;
	int                  last_latency;

	`include "gru_ref.svh"

	gru_top u_dut (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.x_in   (x_in),
		.h_prev (h_prev),
		.h_out  (h_out),
		.busy   (busy),
		.valid  (valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// compare and stop
	//////////////////////////////////////////////////

	task automatic fail_stop;
		err_count++;
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_state(input string name, input gru_pkg::vec_state_t got,
		input gru_pkg::vec_state_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			fail_stop();
		end
	endtask

	// galois form, x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// twelve bits, sign extended, about +-8.0
	task automatic random_fix(output gru_pkg::fix_t v);
		logic [11:0] bits;
		int          i;
		for (i = 0; i < 12; i++) begin
			lfsr    = lfsr_next(lfsr);
			bits[i] = lfsr[0];
		end
		v = gru_pkg::fix_t'(signed'(bits));
	endtask

	task automatic wait_for_valid(output int cycles);
		cycles = 0;
		while (valid !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("timeout at %0t: no valid within %0d cycles of start",
					$time, TIMEOUT_CYCLES);
				fail_stop();
			end
		end
	endtask

	task automatic step_and_check(input gru_pkg::vec_in_t x, input gru_pkg::vec_state_t h,
		output gru_pkg::vec_state_t got);
		gru_pkg::vec_state_t exp;
		int                  waited;
		exp    = ref_step(x, h);
		x_in   = x;
		h_prev = h;
		start  = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_bit("busy", busy, 1'b1);
		wait_for_valid(waited);
		// falling edges from start to valid
		last_latency = waited + 1;
		check_state("h_out", h_out, exp);
		check_bit("busy", busy, 1'b1);
		got = h_out;
		@(negedge clk);
		check_bit("valid", valid, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_state("h_out", h_out, exp);
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic test_reset_values;
		check_bit("busy", busy, 1'b0);
		check_bit("valid", valid, 1'b0);
		check_state("h_out", h_out, '0);
	endtask

	task automatic test_fixed_vectors;
		gru_pkg::vec_state_t got;
		// biases only
		step_and_check('0, '0, got);
		step_and_check({16'shff80, 16'sh0100}, {16'shffc0, 16'sh0040}, got);
		step_and_check({16'sh0230, 16'shfe90}, {16'sh00c0, 16'shff10}, got);
		// sums saturate, activations clamp
		step_and_check({16'sh8000, 16'sh7fff}, {16'sh7000, 16'sh7fff}, got);
		step_and_check({16'sh7fff, 16'sh8000}, {16'sh8000, 16'sh9000}, got);
	endtask

	task automatic test_start_while_busy;
		gru_pkg::vec_state_t exp;
		gru_pkg::vec_state_t got;
		int                  pulses;
		int                  seen_at;
		int                  i;
		// undisturbed run with the same vectors sets the latency
		step_and_check({16'sh0180, 16'shfe00}, {16'sh0020, 16'sh0100}, got);
		exp     = ref_step(x_in, h_prev);
		pulses  = 0;
		seen_at = 0;
		for (i = 0; i < 60; i++) begin
			if (i == 0) begin
				start = 1'b1;
			end else if (i == 4 || i == 14) begin
				check_bit("busy", busy, 1'b1);
				start = 1'b1;
			end else begin
				start = 1'b0;
			end
			@(negedge clk);
			if (valid === 1'b1) begin
				pulses++;
				seen_at = i + 1;
				check_state("h_out", h_out, exp);
			end
		end
		if (pulses != 1) begin
			$display("start while busy gave %0d valid pulses instead of one", pulses);
			fail_stop();
		end
		// a restart on the extra pulse would delay valid
		if (seen_at != last_latency) begin
			$display("MISMATCH at %0t: valid latency got %0d expected %0d",
				$time, seen_at, last_latency);
			fail_stop();
		end
		check_bit("busy", busy, 1'b0);
		check_state("h_out", h_out, exp);
	endtask

	task automatic test_random_chain;
		gru_pkg::vec_in_t    x;
		gru_pkg::vec_state_t h;
		gru_pkg::vec_state_t got;
		gru_pkg::fix_t       v;
		int                  k;
		int                  i;
		for (i = 0; i < gru_pkg::N_NEURONS; i++) begin
			random_fix(v);
			h[i*gru_pkg::FIX_W +: gru_pkg::FIX_W] = v;
		end
		for (k = 0; k < RANDOM_RUNS; k++) begin
			for (i = 0; i < gru_pkg::N_INPUTS; i++) begin
				random_fix(v);
				x[i*gru_pkg::FIX_W +: gru_pkg::FIX_W] = v;
			end
			step_and_check(x, h, got);
			// new state feeds the next step
			h = got;
		end
	endtask

	initial begin
		err_count    = 0;
		last_latency = 0;
		lfsr         = 32'hac2c;
		reset        = 1'b1;
		start        = 1'b0;
		x_in         = '0;
		h_prev       = '0;
		$readmemh("sim/gru_weights.mem", ref_weights);
		repeat (3) @(negedge clk);
		reset = 1'b0;

		test_reset_values();
		test_fixed_vectors();
		test_start_while_busy();
		test_random_chain();

		if (err_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: sim/gru_weights.mem
// one signed Q8.8 word per line in hex
// rows of bias, w_x0, w_x1, w_h0, w_h1; blocks z, r, h; neuron 0 then 1
0020 // z n0
0080
ff40
0060
ffa0
ffe0 // z n1
0050
00c0
ff90
0030
0010 // r n0
ff60
0070
0040
00a0
fff0 // r n1
00b0
ff50
ffc0
0058
0008 // h n0
0120
ff30
00d0
ff88
ffd8 // h n1
ff70
0140
0068
00e0

// File: sim.f
+incdir+sim
common/gru_pkg.sv
hw/gru/gru_sequencer.sv
hw/gru/gru_weight_rom.sv
hw/gru/gru_mac.sv
hw/gru/gru_state_update.sv
hw/gru/gru_top.sv
sim/gru_chk.sv
sim/tb_gru.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_gru
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
MEM_SRC   ?= sim/gru_weights.mem
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

# the rom opens its data file from the run directory
MEM_RUN = gru_weights.mem
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	cp $(MEM_SRC) $(MEM_RUN)
	-$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG) $(MEM_RUN)
